/* source/rv32i_types.sv */
package rv32i_types;

    // line geometry shared by cache, adapter and memory side
    localparam int LINE_BYTES     = 32;
    localparam int BEATS_PER_LINE = 4;

    // cache to burst memory
    typedef struct packed {
        logic [31:0] addr;      // line aligned
        logic        read;      // one cycle pulse
    } bmem_req_t;

    // burst memory to adapter, one 64-bit beat at a time
    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        logic        valid;
    } bmem_resp_t;

    // fetch to cache
    typedef struct packed {
        logic [31:0] addr;      // word address
        logic        read;
    } fetch_req_t;

    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_MISS,
        CACHE_FILL
    } icache_state_t;

endpackage

/* source/cacheline_adapter.sv */
`timescale 1ns/1ps

module cacheline_adapter (
    input  logic                                   clk,
    input  logic                                   rst,

    input  rv32i_types::bmem_resp_t                beat_i,

    output logic [rv32i_types::LINE_BYTES*8-1:0]   line_o,
    output logic                                   line_valid_o
);

    localparam int BEAT_BITS   = rv32i_types::LINE_BYTES * 8 / rv32i_types::BEATS_PER_LINE;
    localparam int CNT_BITS    = $clog2(rv32i_types::BEATS_PER_LINE);
    localparam int OFFSET_BITS = $clog2(rv32i_types::LINE_BYTES);

    logic [CNT_BITS-1:0] beat_cnt_q;
    logic                last_beat;

    assign last_beat = (beat_cnt_q == CNT_BITS'(rv32i_types::BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            line_valid_o <= 1'b0;
        end else begin
            // pulse lands the cycle after the last beat
            line_valid_o <= beat_i.valid && last_beat;
            if (beat_i.valid) begin
                if (last_beat) begin
                    beat_cnt_q <= '0;     // ready for the next burst
                end else begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                end
            end
        end
    end

    // beats arrive lowest address first, so the counter is the slot
    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            line_o[beat_cnt_q*BEAT_BITS +: BEAT_BITS] <= beat_i.data;
        end
    end

    // beat offset within the line has to match the slot it goes into
    a_beat_in_order: assert property (
        @(posedge clk) disable iff (rst)
        beat_i.valid |-> beat_i.addr[OFFSET_BITS-1 -: CNT_BITS] == beat_cnt_q
    ) else $error("memory beat out of address order");

endmodule

/* source/icache.sv */
`timescale 1ns/1ps

module icache #(
    parameter int NUM_SETS = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,

    input  rv32i_types::fetch_req_t                fetch_req_i,
    output logic [31:0]                            rdata_o,
    output logic                                   resp_o,

    output logic [31:0]                            mem_addr_o,
    output logic                                   mem_read_o,
    input  logic [rv32i_types::LINE_BYTES*8-1:0]   line_i,
    input  logic                                   line_valid_i
);

    localparam int LINE_BITS   = rv32i_types::LINE_BYTES * 8;
    localparam int OFFSET_BITS = $clog2(rv32i_types::LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - OFFSET_BITS - INDEX_BITS;
    localparam int WORD_BITS   = OFFSET_BITS - 2;

    rv32i_types::icache_state_t state_q, state_d;

    logic [LINE_BITS-1:0]  data_q [NUM_SETS];
    logic [TAG_BITS-1:0]   tag_q  [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;

    logic [31:0]           miss_addr_q;
    logic [31:0]           hit_word_q;
    logic                  hit_resp_q;

    logic [INDEX_BITS-1:0] req_index, miss_index;
    logic [TAG_BITS-1:0]   req_tag, miss_tag;
    logic [WORD_BITS-1:0]  req_word, miss_word;
    logic [LINE_BITS-1:0]  req_line, miss_line;
    logic                  lookup;
    logic                  hit;

    assign req_index  = fetch_req_i.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = fetch_req_i.addr[31 -: TAG_BITS];
    assign req_word   = fetch_req_i.addr[OFFSET_BITS-1:2];
    assign miss_index = miss_addr_q[OFFSET_BITS +: INDEX_BITS];
    assign miss_tag   = miss_addr_q[31 -: TAG_BITS];
    assign miss_word  = miss_addr_q[OFFSET_BITS-1:2];

    assign req_line  = data_q[req_index];
    assign miss_line = data_q[miss_index];    // already installed once in FILL

    // FILL can take the next request, fetch issues on the resp cycle
    assign lookup = fetch_req_i.read && (state_q != rv32i_types::CACHE_MISS);
    assign hit    = valid_q[req_index] && (tag_q[req_index] == req_tag);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            rv32i_types::CACHE_IDLE,
            rv32i_types::CACHE_FILL: begin
                if (lookup && !hit) begin
                    state_d = rv32i_types::CACHE_MISS;
                end else begin
                    state_d = rv32i_types::CACHE_IDLE;
                end
            end
            rv32i_types::CACHE_MISS: begin
                if (line_valid_i) begin
                    state_d = rv32i_types::CACHE_FILL;
                end
            end
            default: state_d = rv32i_types::CACHE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= rv32i_types::CACHE_IDLE;
            valid_q    <= '0;
            hit_resp_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            hit_resp_q <= lookup && hit;
            if (state_q == rv32i_types::CACHE_MISS && line_valid_i) begin
                valid_q[miss_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            miss_addr_q <= fetch_req_i.addr;   // only kept when it misses
            hit_word_q  <= req_line[req_word*32 +: 32];
        end
        if (state_q == rv32i_types::CACHE_MISS && line_valid_i) begin
            data_q[miss_index] <= line_i;
            tag_q[miss_index]  <= miss_tag;
        end
    end

    assign mem_read_o = (state_q == rv32i_types::CACHE_MISS);
    assign mem_addr_o = {miss_addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // hits answer from the register, fills straight from the new line
    assign resp_o  = hit_resp_q || (state_q == rv32i_types::CACHE_FILL);
    assign rdata_o = (state_q == rv32i_types::CACHE_FILL) ? miss_line[miss_word*32 +: 32]
                                                          : hit_word_q;

    // adapter only delivers a line for a burst this cache asked for
    a_line_only_in_miss: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_i |-> state_q == rv32i_types::CACHE_MISS
    ) else $error("line_valid outside of a miss");

endmodule

/* source/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] wdata_i,
    input  logic        push_i,
    input  logic        pop_i,

    output logic [31:0] rdata_o,
    output logic        empty_o,
    output logic        near_full_o
);

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    logic [31:0]         mem_q [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_BITS-1:0] count_q;
    logic                do_pop;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] next;
        next = (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return next;
    endfunction

    assign do_pop = pop_i && !empty_o;    // pops on empty are dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            unique case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

    // one slot kept back for the response still in flight
    assign near_full_o = (count_q >= CNT_BITS'(QUEUE_DEPTH - 1));

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        push_i |-> count_q != CNT_BITS'(QUEUE_DEPTH)
    ) else $error("push into full instruction queue");

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= CNT_BITS'(QUEUE_DEPTH)
    ) else $error("instruction queue count out of range");

endmodule

/* source/cpu_frontend.sv */
`timescale 1ns/1ps

module cpu_frontend #(
    parameter logic [31:0] RESET_PC    = 32'h1eceb000,
    parameter int          NUM_SETS    = 16,
    parameter int          QUEUE_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    bmem_ready_i,
    input  rv32i_types::bmem_resp_t bmem_resp_i,
    input  logic                    dequeue_i,

    output rv32i_types::bmem_req_t  bmem_req_o,
    output logic [31:0]             inst_o,
    output logic                    empty_o
);

    localparam int LINE_BITS   = rv32i_types::LINE_BYTES * 8;
    localparam int OFFSET_BITS = $clog2(rv32i_types::LINE_BYTES);

    logic [31:0]            pc_q, pc_d;
    logic                   first_q, first_d;
    logic                   read_sent_q;

    logic                   stall;
    logic                   issue;
    rv32i_types::fetch_req_t fetch_req;

    logic [31:0]            cache_rdata;
    logic                   cache_resp;
    logic [31:0]            mem_addr;
    logic                   mem_read;
    logic                   read_pulse;

    logic [LINE_BITS-1:0]   line;
    logic                   line_valid;
    logic                   near_full;

    assign stall = near_full || !bmem_ready_i;

    // only one request in flight and the next goes out with the resp
    assign issue = (first_q || cache_resp) && !stall && !rst;

    always_comb begin
        pc_d = issue ? pc_q + 32'd4 : pc_q;
        // a resp swallowed by a stall re-arms the flag for later
        first_d = stall && (first_q || cache_resp);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= RESET_PC;
            first_q     <= 1'b1;
            read_sent_q <= 1'b0;
        end else begin
            pc_q        <= pc_d;
            first_q     <= first_d;
            read_sent_q <= mem_read && (read_sent_q || read_pulse);   // held until the line is in
        end
    end

    assign fetch_req.addr = pc_q;
    assign fetch_req.read = issue;

    // rising edge of the miss level held back while memory is not ready
    assign read_pulse = mem_read && !read_sent_q && bmem_ready_i;

    assign bmem_req_o.addr = mem_addr;
    assign bmem_req_o.read = read_pulse;

    icache #(
        .NUM_SETS     (NUM_SETS)
    ) icache_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req),
        .rdata_o      (cache_rdata),
        .resp_o       (cache_resp),
        .mem_addr_o   (mem_addr),
        .mem_read_o   (mem_read),
        .line_i       (line),
        .line_valid_i (line_valid)
    );

    cacheline_adapter adapter_i (
        .clk          (clk),
        .rst          (rst),
        .beat_i       (bmem_resp_i),
        .line_o       (line),
        .line_valid_o (line_valid)
    );

    inst_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) queue_i (
        .clk          (clk),
        .rst          (rst),
        .wdata_i      (cache_rdata),
        .push_i       (cache_resp),
        .pop_i        (dequeue_i),
        .rdata_o      (inst_o),
        .empty_o      (empty_o),
        .near_full_o  (near_full)
    );

    // a new burst only starts once the previous one is fully in
    a_read_bus_idle: assert property (
        @(posedge clk) disable iff (rst)
        read_pulse |-> !bmem_resp_i.valid && !line_valid
    ) else $error("bmem read pulse while a burst is still arriving");

    // beats must belong to the line the cache is missing on
    a_beat_in_line: assert property (
        @(posedge clk) disable iff (rst)
        bmem_resp_i.valid |-> mem_read &&
            bmem_resp_i.addr[31:OFFSET_BITS] == mem_addr[31:OFFSET_BITS]
    ) else $error("bmem beat outside the requested line");

endmodule

/* dv/bmem_model.sv */
`timescale 1ns/1ps

module bmem_model (
    input  logic                    clk,
    input  logic                    rst,

    input  rv32i_types::bmem_req_t  req_i,
    input  logic [31:0]             rand_i,         // fresh random word every cycle
    input  logic [63:0]             lookup_data_i,  // contents at lookup_addr_o

    output logic [31:0]             lookup_addr_o,
    output logic                    ready_o,
    output rv32i_types::bmem_resp_t resp_o,
    output logic                    overlap_o
);

    localparam int BEAT_BYTES = rv32i_types::LINE_BYTES / rv32i_types::BEATS_PER_LINE;

    rv32i_types::bmem_resp_t resp_q = '0;
    logic                    ready_q   = 1'b0;
    logic                    overlap_q = 1'b0;
    logic                    busy_q    = 1'b0;
    logic [31:0]             base_q    = '0;
    logic [1:0]              beat_q    = '0;
    logic [3:0]              wait_q    = '0;

    assign lookup_addr_o = base_q + 32'(beat_q) * BEAT_BYTES;
    assign ready_o       = ready_q;
    assign resp_o        = resp_q;
    assign overlap_o     = overlap_q;

    always @(posedge clk) begin
        ready_q      <= (rand_i[23:16] >= 8'd26);   // roughly one cycle in ten dropped
        resp_q.valid <= 1'b0;
        if (rst) begin
            busy_q <= 1'b0;
        end else if (req_i.read) begin
            if (busy_q) begin
                $display("memory model: read pulse for %h while a burst is still outstanding",
                         req_i.addr);
                overlap_q <= 1'b1;
            end
            busy_q <= 1'b1;
            base_q <= req_i.addr;
            beat_q <= '0;
            wait_q <= 4'(rand_i[29:27]) + 4'd1;     // latency to first beat
        end else if (busy_q) begin
            if (wait_q != '0) begin
                wait_q <= wait_q - 4'd1;
            end else begin
                resp_q.valid <= 1'b1;
                resp_q.addr  <= lookup_addr_o;
                resp_q.data  <= lookup_data_i;
                wait_q       <= 4'(rand_i[31:30]);  // gap of 0 to 3 cycles
                if (beat_q == 2'(rv32i_types::BEATS_PER_LINE - 1)) begin
                    busy_q <= 1'b0;
                end else begin
                    beat_q <= beat_q + 2'd1;
                end
            end
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam logic [31:0] RESET_PC        = 32'h1eceb000;
    localparam logic [31:0] LINE_BYTES      = 32'd32;
    localparam int          NUM_INSTS       = 400;
    localparam int          CYCLES_PER_INST = 40;
    localparam int          RESET_CYCLES    = 16;
    localparam int          HOLD_CYCLES     = 48;

    logic                    clk;
    logic                    rst;
    logic                    dequeue = 1'b0;
    logic                    bmem_ready;
    rv32i_types::bmem_req_t  bmem_req;
    rv32i_types::bmem_resp_t bmem_resp;
    logic [31:0]             inst;
    logic                    empty;

    logic [31:0] rng      = 32'h11e90221;
    logic [31:0] mem_rand = '0;
    logic [31:0] lookup_addr;
    logic [63:0] lookup_data;
    logic        overlap;

    logic [31:0] exp_pc     = RESET_PC;
    logic [31:0] next_line  = RESET_PC;  // line of the next read the model expects
    int          hold_cnt   = 0;
    int          checked    = 0;
    int          read_count = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory contents, a fixed scramble of the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5bd1e995;
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 15);
        x = x * 32'h85ebca6b;
        return x ^ (x >> 13);
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    assign lookup_data = {mem_word(lookup_addr + 32'd4), mem_word(lookup_addr)};

    cpu_frontend dut (
        .clk          (clk),
        .rst          (rst),
        .bmem_ready_i (bmem_ready),
        .bmem_resp_i  (bmem_resp),
        .dequeue_i    (dequeue),
        .bmem_req_o   (bmem_req),
        .inst_o       (inst),
        .empty_o      (empty)
    );

    bmem_model mem_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (bmem_req),
        .rand_i        (mem_rand),
        .lookup_data_i (lookup_data),
        .lookup_addr_o (lookup_addr),
        .ready_o       (bmem_ready),
        .resp_o        (bmem_resp),
        .overlap_o     (overlap)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    always @(posedge clk) begin
        logic [31:0] roll_deq;
        logic [31:0] roll_hold;
        roll_deq  = lcg_next(rng);
        roll_hold = lcg_next(roll_deq);
        rng       = lcg_next(roll_hold);
        mem_rand <= rng;
        if (rst) begin
            dequeue <= 1'b0;
        end else if (hold_cnt > 0) begin
            dequeue  <= 1'b0;                  // consumer stalls, queue fills up
            hold_cnt <= hold_cnt - 1;
        end else begin
            dequeue <= (roll_deq[31:24] < 8'd154);
            if (roll_hold[31:24] < 8'd3) hold_cnt <= HOLD_CYCLES;
        end
    end

    // outputs sampled mid cycle, the pop happens at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (overlap) begin
                $display("memory model saw a read pulse during an outstanding burst");
                stop_with_failure();
            end
            if (bmem_req.read) begin
                compare_value("bmem_ready_i", {31'b0, bmem_ready}, 32'd1);
                compare_value("bmem_req_o.addr", bmem_req.addr, next_line);
                next_line  = next_line + LINE_BYTES;
                read_count = read_count + 1;
            end
            if (dequeue && !empty) begin
                compare_value("inst_o", inst, mem_word(exp_pc));
                exp_pc  = exp_pc + 32'd4;
                checked = checked + 1;
            end
            if (checked == NUM_INSTS) begin
                $display("%0d words checked, %0d line reads", checked, read_count);
                $display("sim passed");
                $finish;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_INSTS * CYCLES_PER_INST) @(posedge clk);
        $display("timeout: only %0d of %0d words were dequeued", checked, NUM_INSTS);
        stop_with_failure();
    end

endmodule

/* all.f */
source/rv32i_types.sv
source/cacheline_adapter.sv
source/icache.sv
source/inst_queue.sv
source/cpu_frontend.sv
dv/bmem_model.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f all.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_top >> sim.log 2>&1 \
    || echo "sim failed" >> sim.log
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
